/* hdl/stream_pkg.sv */
// stream side types: input beat, extracted flow record, axi4-lite read channel
`default_nettype none

package stream_pkg;

    //////////////////////////////////////////////////
    // input stream
    //////////////////////////////////////////////////
    localparam int DATA_BYTES = 8;                  // 64 bit tdata

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] tdata;
        logic [DATA_BYTES-1:0]   tkeep;
        logic [15:0]             tuser;             // packet length, first beat only
        logic                    tlast;
        logic                    tvalid;
    } axis_beat_t;

    //////////////////////////////////////////////////
    // flow record
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [7:0]  proto;                         // ipv4 protocol field
    } five_tuple_t;                                 // 104 bits

    typedef struct packed {
        five_tuple_t tuple;
        logic [15:0] byte_len;
        logic        valid;                         // one cycle pulse per packet
    } flow_rec_t;

    //////////////////////////////////////////////////
    // axi4-lite read channel
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [11:0] araddr;                        // byte address
        logic        arvalid;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_r_t;

endpackage

`default_nettype wire

/* hdl/sketch_pkg.sv */
// sketch side definitions: hash constants, table entry, readout word, register map
`default_nettype none

package sketch_pkg;

    //////////////////////////////////////////////////
    // hashing
    //////////////////////////////////////////////////
    localparam logic [31:0] HASH_MULT_IDX = 32'h9e3779b1;  // golden ratio, odd
    localparam logic [31:0] HASH_MULT_TAG = 32'h85ebca6b;  // second odd multiplier

    // xor the tuple down to one 32 bit key
    // three full words plus the protocol byte
    function automatic logic [31:0] fold_tuple(input logic [103:0] tuple);
        logic [31:0] key;
        key = tuple[103:72] ^ tuple[71:40] ^ tuple[39:8];
        key = key ^ {24'h0, tuple[7:0]};
        return key;
    endfunction

    //////////////////////////////////////////////////
    // table entry and readout
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [15:0] tag;                           // flow id of current owner
        logic [15:0] bytes;                         // saturating byte count
    } sketch_entry_t;

    // one rdata word, entry view or plain counter view
    typedef union packed {
        sketch_entry_t entry;
        logic [31:0]   count;
    } sketch_word_u;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////
    localparam logic [11:0] COLLISION_ADDR = 12'h800;   // collision counter
    localparam logic [1:0]  RESP_OKAY      = 2'b00;
    localparam logic [1:0]  RESP_SLVERR    = 2'b10;

endpackage

`default_nettype wire

/* hdl/flow_collector.sv */
// flow collector, pulls the five-tuple and length out of each packet header
`timescale 1ns/100ps
`default_nettype none

module flow_collector
    import stream_pkg::*;
(
    input  logic       clk,
    input  logic       memreset,
    input  axis_beat_t s_axis,
    output logic       s_axis_tready,
    output flow_rec_t  rec
);

    logic [2:0]  beat_cnt;      // beat index in packet, sticks at 5
    logic        tready_q;
    logic        valid_q;
    five_tuple_t tuple_q;       // header fields, filled beat by beat
    logic [15:0] len_q;
    logic        xfer;

    assign xfer          = s_axis.tvalid & tready_q;
    assign s_axis_tready = tready_q;

    //////////////////////////////////////////////////
    // beat counting and record qualify
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            beat_cnt <= '0;
            valid_q  <= 1'b0;
            tready_q <= 1'b0;
        end
        else
        begin
            tready_q <= 1'b1;                       // never back-pressure
            valid_q  <= 1'b0;
            if (xfer)
            begin
                if (s_axis.tlast)
                begin
                    beat_cnt <= '0;
                    valid_q  <= (beat_cnt >= 3'd4); // 5 beats or more
                end
                else if (beat_cnt != 3'd5)
                    beat_cnt <= beat_cnt + 3'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // header capture, big-endian fields
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            case (beat_cnt)
                3'd0: len_q <= s_axis.tuser;                    // length from tuser
                3'd2: tuple_q.proto <= s_axis.tdata[63:56];     // byte 23
                3'd3:
                begin
                    // bytes 26..29 then 30,31
                    tuple_q.src_ip <= {s_axis.tdata[23:16], s_axis.tdata[31:24],
                                       s_axis.tdata[39:32], s_axis.tdata[47:40]};
                    tuple_q.dst_ip[31:16] <= {s_axis.tdata[55:48], s_axis.tdata[63:56]};
                end
                3'd4:
                begin
                    tuple_q.dst_ip[15:0] <= {s_axis.tdata[7:0], s_axis.tdata[15:8]};
                    tuple_q.src_port <= {s_axis.tdata[23:16], s_axis.tdata[31:24]};
                    tuple_q.dst_port <= {s_axis.tdata[39:32], s_axis.tdata[47:40]};
                end
                default: ;                                      // payload beats
            endcase
        end
    end

    assign rec.tuple    = tuple_q;
    assign rec.byte_len = len_q;
    assign rec.valid    = valid_q;

endmodule

`default_nettype wire

/* hdl/flow_hash.sv */
// flow hash, one registered multiply-shift stage giving table index and tag
`timescale 1ns/100ps
`default_nettype none

module flow_hash
    import stream_pkg::*;
    import sketch_pkg::*;
#(
    parameter int unsigned INDEX_BITS = 6
)
(
    input  logic                  clk,
    input  logic                  memreset,
    input  flow_rec_t             rec,
    output logic                  upd_valid,
    output logic [INDEX_BITS-1:0] upd_index,
    output logic [15:0]           upd_tag,
    output logic [15:0]           upd_bytes
);

    logic [31:0] key;
    logic [31:0] prod_idx;      // low word of key * mult
    logic [31:0] prod_tag;

    always_comb
    begin
        key      = fold_tuple(rec.tuple);
        prod_idx = key * HASH_MULT_IDX;             // keeps low 32 bits
        prod_tag = key * HASH_MULT_TAG;
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
            upd_valid <= 1'b0;
        else
            upd_valid <= rec.valid;
    end

    // top bits of the product are the well mixed ones
    always_ff @(posedge clk)
    begin
        if (rec.valid)
        begin
            upd_index <= prod_idx[31 -: INDEX_BITS];
            upd_tag   <= prod_tag[31:16];
            upd_bytes <= rec.byte_len;
        end
    end

endmodule

`default_nettype wire

/* hdl/sketch_table.sv */
// sketch table, tag-checked byte accumulation per index plus collision count
`timescale 1ns/100ps
`default_nettype none

module sketch_table
    import sketch_pkg::*;
#(
    parameter int unsigned INDEX_BITS = 6
)
(
    input  logic                  clk,
    input  logic                  memreset,
    input  logic                  upd_valid,
    input  logic [INDEX_BITS-1:0] upd_index,
    input  logic [15:0]           upd_tag,
    input  logic [15:0]           upd_bytes,
    input  logic [INDEX_BITS-1:0] rd_index,
    output sketch_entry_t         rd_entry,
    output logic [31:0]           collisions
);

    localparam int unsigned DEPTH = 2**INDEX_BITS;

    sketch_entry_t entries [DEPTH];
    sketch_entry_t cur;                 // entry under update
    logic          keep_owner;          // empty slot or same flow
    logic [16:0]   sum;                 // carry out marks overflow
    logic [15:0]   sat_bytes;

    //////////////////////////////////////////////////
    // read side of the read-modify-write
    //////////////////////////////////////////////////
    always_comb
    begin
        cur        = entries[upd_index];
        keep_owner = (cur.bytes == 16'h0) || (cur.tag == upd_tag);
        sum        = {1'b0, cur.bytes} + {1'b0, upd_bytes};
        sat_bytes  = sum[16] ? 16'hffff : sum[15:0];   // clamp at max
    end

    //////////////////////////////////////////////////
    // write back
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            for (int i = 0; i < DEPTH; i++)
                entries[i] <= '0;           // table reads zero after reset
            collisions <= '0;
        end
        else if (upd_valid)
        begin
            if (keep_owner)
            begin
                entries[upd_index].tag   <= upd_tag;
                entries[upd_index].bytes <= sat_bytes;
            end
            else
            begin
                // different flow owns the slot, evict it
                entries[upd_index].tag   <= upd_tag;
                entries[upd_index].bytes <= upd_bytes;
                collisions <= collisions + 32'd1;
            end
        end
    end

    // readout port, combinational
    assign rd_entry = entries[rd_index];

endmodule

`default_nettype wire

/* hdl/sketch_axil_read.sv */
// axi4-lite read slave for the sketch entries and the collision counter
`timescale 1ns/100ps
`default_nettype none

module sketch_axil_read
    import stream_pkg::*;
    import sketch_pkg::*;
#(
    parameter int unsigned INDEX_BITS = 6
)
(
    input  logic                  clk,
    input  logic                  memreset,
    input  axil_ar_t              ar,
    output logic                  arready,
    input  logic                  rready,
    output axil_r_t               r,
    output logic [INDEX_BITS-1:0] rd_index,
    input  sketch_entry_t         rd_entry,
    input  logic [31:0]           collisions
);

    localparam int unsigned DEPTH = 2**INDEX_BITS;

    logic         ar_hs;            // address accepted this cycle
    logic         in_table;
    logic         is_coll;
    logic         rvalid_nxt;
    sketch_word_u word_d;           // response word before register
    logic [1:0]   resp_d;

    assign ar_hs    = ar.arvalid & arready;
    assign rd_index = ar.araddr[INDEX_BITS+1:2];            // word index
    assign in_table = (ar.araddr[11:2] < 10'(DEPTH));
    assign is_coll  = (ar.araddr == COLLISION_ADDR);

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////
    always_comb
    begin
        word_d.count = '0;
        resp_d       = RESP_SLVERR;                         // unmapped by default
        if (in_table)
        begin
            word_d.entry = rd_entry;                        // {tag, bytes}
            resp_d       = RESP_OKAY;
        end
        else if (is_coll)
        begin
            word_d.count = collisions;
            resp_d       = RESP_OKAY;
        end
    end

    // one outstanding read, hold until rready
    assign rvalid_nxt = ar_hs | (r.rvalid & ~rready);

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            r.rvalid <= 1'b0;
            arready  <= 1'b0;
        end
        else
        begin
            r.rvalid <= rvalid_nxt;
            arready  <= ~rvalid_nxt;                        // free again once accepted
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_hs)
        begin
            r.rdata <= word_d.count;
            r.rresp <= resp_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/flow_sketch_top.sv */
// flow sketch top, stream collector to hash to table, read out over axi4-lite
`timescale 1ns/100ps
`default_nettype none

module flow_sketch_top
    import stream_pkg::*;
    import sketch_pkg::*;
#(
    parameter int unsigned INDEX_BITS = 6       // 64 entries by default
)
(
    input  logic       clk,
    input  logic       memreset,
    input  axis_beat_t s_axis,
    output logic       s_axis_tready,
    input  axil_ar_t   s_axil_ar,
    output logic       s_axil_arready,
    input  logic       s_axil_rready,
    output axil_r_t    s_axil_r
);

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////
    flow_rec_t             rec;                 // collector to hash
    logic                  upd_valid;           // hash to table
    logic [INDEX_BITS-1:0] upd_index;
    logic [15:0]           upd_tag;
    logic [15:0]           upd_bytes;
    logic [INDEX_BITS-1:0] rd_index;            // read slave to table
    sketch_entry_t         rd_entry;
    logic [31:0]           collisions;

    flow_collector u_flow_collector (
        .clk           (clk),
        .memreset      (memreset),
        .s_axis        (s_axis),
        .s_axis_tready (s_axis_tready),
        .rec           (rec)
    );

    flow_hash #(.INDEX_BITS(INDEX_BITS)) u_flow_hash (
        .clk       (clk),
        .memreset  (memreset),
        .rec       (rec),
        .upd_valid (upd_valid),
        .upd_index (upd_index),
        .upd_tag   (upd_tag),
        .upd_bytes (upd_bytes)
    );

    sketch_table #(.INDEX_BITS(INDEX_BITS)) u_sketch_table (
        .clk        (clk),
        .memreset   (memreset),
        .upd_valid  (upd_valid),
        .upd_index  (upd_index),
        .upd_tag    (upd_tag),
        .upd_bytes  (upd_bytes),
        .rd_index   (rd_index),
        .rd_entry   (rd_entry),
        .collisions (collisions)
    );

    sketch_axil_read #(.INDEX_BITS(INDEX_BITS)) u_sketch_axil_read (
        .clk        (clk),
        .memreset   (memreset),
        .ar         (s_axil_ar),
        .arready    (s_axil_arready),
        .rready     (s_axil_rready),
        .r          (s_axil_r),
        .rd_index   (rd_index),
        .rd_entry   (rd_entry),
        .collisions (collisions)
    );

endmodule

`default_nettype wire

/* verification/flow_sketch_tb.sv */
// flow sketch testbench that checks packet traffic against a reference model of the table
`timescale 1ns/100ps
`default_nettype none

module flow_sketch_tb
    import stream_pkg::*;
    import sketch_pkg::*;
();

    localparam int          IDX_BITS   = 6;
    localparam int          DEPTH      = 2**IDX_BITS;
    localparam int          WAIT_LIMIT = 100;           // cycles per handshake wait
    localparam logic [31:0] LFSR_SEED  = 32'h58acc24a;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;  // x^32+x^22+x^2+x+1

    logic       clk = 1'b0;
    logic       memreset;
    axis_beat_t s_axis;
    logic       s_axis_tready;
    axil_ar_t   s_axil_ar;
    logic       s_axil_arready;
    logic       s_axil_rready;
    axil_r_t    s_axil_r;

    logic [31:0] lfsr_state;
    logic [15:0] model_tag   [DEPTH];   // expected table contents
    logic [15:0] model_bytes [DEPTH];
    logic [31:0] model_coll;

    always #5 clk = ~clk;               // 10 ns

    flow_sketch_top #(.INDEX_BITS(IDX_BITS)) u_flow_sketch_top (
        .clk            (clk),
        .memreset       (memreset),
        .s_axis         (s_axis),
        .s_axis_tready  (s_axis_tready),
        .s_axil_ar      (s_axil_ar),
        .s_axil_arready (s_axil_arready),
        .s_axil_rready  (s_axil_rready),
        .s_axil_r       (s_axil_r)
    );

    //////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////
    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s at t=%0t", what, $time);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // concurrent checks
    //////////////////////////////////////////////////
    // stream ready in every cycle after reset
    assert property (@(posedge clk) disable iff (memreset) !$past(memreset) |-> s_axis_tready)
        else value_error("s_axis_tready", 32'd1, {31'd0, s_axis_tready});

    // arready high exactly when no response pending
    assert property (@(posedge clk) disable iff (memreset)
        !$past(memreset) |-> (s_axil_arready == !s_axil_r.rvalid))
        else value_error("s_axil_arready", {31'd0, !s_axil_r.rvalid}, {31'd0, s_axil_arready});

    // held response keeps rvalid up
    assert property (@(posedge clk) disable iff (memreset)
        s_axil_r.rvalid && !s_axil_rready |=> s_axil_r.rvalid)
        else value_error("s_axil_r.rvalid", 32'd1, {31'd0, s_axil_r.rvalid});

    //////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    function automatic five_tuple_t random_tuple();
        five_tuple_t t;
        t.src_ip   = lfsr_bits(32);
        t.dst_ip   = lfsr_bits(32);
        t.src_port = lfsr_bits(16);
        t.dst_port = lfsr_bits(16);
        t.proto    = lfsr_bits(1) ? 8'd17 : 8'd6;  // udp or tcp
        return t;
    endfunction

    // xor of ips, port pair and protocol byte
    function automatic logic [31:0] flow_key(input five_tuple_t t);
        return t.src_ip ^ t.dst_ip ^ {t.src_port, t.dst_port} ^ {24'h0, t.proto};
    endfunction

    function automatic logic [IDX_BITS-1:0] flow_index(input five_tuple_t t);
        logic [31:0] p;
        p = flow_key(t) * HASH_MULT_IDX;
        return p[31 -: IDX_BITS];
    endfunction

    function automatic logic [15:0] flow_tag(input five_tuple_t t);
        logic [31:0] p;
        p = flow_key(t) * HASH_MULT_TAG;
        return p[31:16];
    endfunction

    function automatic void model_update(input five_tuple_t t, input logic [15:0] len);
        logic [IDX_BITS-1:0] idx;
        logic [15:0]         tag;
        logic [16:0]         sum;
        idx = flow_index(t);
        tag = flow_tag(t);
        if (model_bytes[idx] == 16'h0 || model_tag[idx] == tag)
        begin
            sum              = {1'b0, model_bytes[idx]} + {1'b0, len};
            model_bytes[idx] = sum[16] ? 16'hffff : sum[15:0];     // saturate
        end
        else
        begin
            model_bytes[idx] = len;         // owner evicted
            model_coll       = model_coll + 32'd1;
        end
        model_tag[idx] = tag;
    endfunction

    //////////////////////////////////////////////////
    // stream driver
    //////////////////////////////////////////////////
    task automatic send_packet(input five_tuple_t t, input logic [15:0] len, input int nbeats);
        logic [7:0] pkt [64];
        int         wait_cnt;
        for (int i = 0; i < 64; i++)
            pkt[i] = 8'(i) ^ 8'h5a;         // payload filler
        pkt[12] = 8'h08;                    // ethertype ipv4
        pkt[13] = 8'h00;
        pkt[14] = 8'h45;
        pkt[23] = t.proto;
        {pkt[26], pkt[27], pkt[28], pkt[29]} = t.src_ip;   // big-endian
        {pkt[30], pkt[31], pkt[32], pkt[33]} = t.dst_ip;
        {pkt[34], pkt[35]} = t.src_port;
        {pkt[36], pkt[37]} = t.dst_port;
        for (int b = 0; b < nbeats; b++)
        begin
            wait_cnt = 0;
            while (!s_axis_tready)
            begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT)
                    abort_run("timed out waiting for s_axis_tready");
            end
            for (int n = 0; n < 8; n++)
                s_axis.tdata[8*n +: 8] = pkt[b*8+n];
            s_axis.tkeep  = 8'hff;
            s_axis.tuser  = (b == 0) ? len : 16'h0;     // length on first beat
            s_axis.tlast  = (b == nbeats - 1);
            s_axis.tvalid = 1'b1;
            @(negedge clk);
        end
        s_axis.tvalid = 1'b0;
        s_axis.tlast  = 1'b0;
    endtask

    // packet then model update if it qualifies then idle gap
    task automatic send_flow(input five_tuple_t t, input logic [15:0] len, input int nbeats,
                             input int gap);
        send_packet(t, len, nbeats);
        if (nbeats >= 5)
            model_update(t, len);
        repeat (gap) @(negedge clk);
    endtask

    // update lands 3 cycles after tlast
    task automatic settle();
        repeat (3) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // axi4-lite reads
    //////////////////////////////////////////////////
    task automatic read_word(input logic [11:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int          wait_cnt;
        logic [31:0] held;
        wait_cnt = 0;
        while (!s_axil_arready)
        begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                abort_run("timed out waiting for arready");
        end
        s_axil_ar.araddr  = addr;
        s_axil_ar.arvalid = 1'b1;
        @(negedge clk);
        s_axil_ar.arvalid = 1'b0;
        wait_cnt = 0;
        while (!s_axil_r.rvalid)
        begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                abort_run("timed out waiting for rvalid");
        end
        held = s_axil_r.rdata;
        for (int i = 0; i < hold; i++)      // response must stay while rready is low
        begin
            @(negedge clk);
            assert (s_axil_r.rvalid)
                else value_error("s_axil_r.rvalid", 32'd1, {31'd0, s_axil_r.rvalid});
            assert (s_axil_r.rdata == held) else value_error("s_axil_r.rdata", held,
                                                             s_axil_r.rdata);
        end
        data = s_axil_r.rdata;
        resp = s_axil_r.rresp;
        s_axil_rready = 1'b1;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic check_entry(input int idx, input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        read_word(12'(idx * 4), hold, data, resp);
        assert (data == {model_tag[idx], model_bytes[idx]})
            else value_error("entry rdata", {model_tag[idx], model_bytes[idx]}, data);
        assert (resp == RESP_OKAY) else value_error("entry rresp", RESP_OKAY, resp);
    endtask

    task automatic check_table();
        for (int i = 0; i < DEPTH; i++)
            check_entry(i, 0);
    endtask

    task automatic check_collisions();
        logic [31:0] data;
        logic [1:0]  resp;
        read_word(COLLISION_ADDR, 0, data, resp);
        assert (data == model_coll) else value_error("collisions", model_coll, data);
        assert (resp == RESP_OKAY) else value_error("collision rresp", RESP_OKAY, resp);
    endtask

    task automatic check_unmapped(input logic [11:0] addr);
        logic [31:0] data;
        logic [1:0]  resp;
        read_word(addr, 0, data, resp);
        assert (data == 32'h0) else value_error("unmapped rdata", 32'h0, data);
        assert (resp == RESP_SLVERR) else value_error("unmapped rresp", RESP_SLVERR, resp);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        five_tuple_t ta;
        five_tuple_t tb;
        five_tuple_t tc;
        five_tuple_t pool [16];
        logic [31:0] data;
        logic [1:0]  resp;
        logic        found;
        int          wait_cnt;

        memreset      = 1'b1;
        s_axis        = '0;
        s_axil_ar     = '0;
        s_axil_rready = 1'b0;
        lfsr_state    = LFSR_SEED;
        model_coll    = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            model_tag[i]   = '0;
            model_bytes[i] = '0;
        end

        // ready and valid outputs stay low in reset
        for (int i = 0; i < 16; i++)
        begin
            @(negedge clk);
            assert (!s_axis_tready)
                else value_error("s_axis_tready", 32'd0, {31'd0, s_axis_tready});
            assert (!s_axil_arready)
                else value_error("s_axil_arready", 32'd0, {31'd0, s_axil_arready});
            assert (!s_axil_r.rvalid)
                else value_error("s_axil_r.rvalid", 32'd0, {31'd0, s_axil_r.rvalid});
        end
        memreset = 1'b0;
        wait_cnt = 0;
        while (!(s_axis_tready && s_axil_arready))
        begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                abort_run("ready signals did not rise after reset");
        end
        check_table();                      // all zero with okay response
        check_collisions();

        // one flow accumulating up to saturation
        ta = random_tuple();
        send_flow(ta, 16'h6000, 6, 1);
        send_flow(ta, 16'h6000, 5, 0);
        settle();
        check_entry(flow_index(ta), 0);
        send_flow(ta, 16'h6000, 7, 2);
        settle();
        read_word(12'(flow_index(ta) * 4), 0, data, resp);
        assert (data == {flow_tag(ta), 16'hffff})
            else value_error("saturated entry", {flow_tag(ta), 16'hffff}, data);

        // second flow on the same index with a different tag
        found = 1'b0;
        tb    = ta;
        for (int p = 0; p < 4096 && !found; p++)
        begin
            tb          = ta;
            tb.src_port = 16'(p) + 16'd1024;
            if (flow_index(tb) == flow_index(ta) && flow_tag(tb) != flow_tag(ta))
                found = 1'b1;
        end
        if (!found)
            abort_run("no second flow found for the shared index");
        send_flow(tb, 16'd100, 5, 1);
        settle();
        check_entry(flow_index(tb), 0);
        read_word(COLLISION_ADDR, 0, data, resp);
        assert (data == 32'd1) else value_error("collisions", 32'd1, data);

        // short packets must leave the table alone
        tc = random_tuple();
        send_flow(tc, 16'd64, 3, 1);
        send_flow(tc, 16'd64, 4, 0);
        send_flow(tb, 16'd64, 1, 2);
        settle();
        check_table();
        check_collisions();

        // unmapped reads and a held response
        check_unmapped(12'h100);            // first word past the table
        check_unmapped(12'h804);
        check_unmapped(12'h7fc);
        check_unmapped(12'hffc);
        check_entry(flow_index(tb), 5);

        // random traffic over a small flow pool
        for (int i = 0; i < 16; i++)
            pool[i] = random_tuple();
        for (int i = 0; i < 48; i++)
            send_flow(pool[lfsr_bits(4)], 16'd46 + 16'(lfsr_bits(10)), 5 + int'(lfsr_bits(2)),
                      int'(lfsr_bits(2)));
        settle();
        check_table();
        check_collisions();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/stream_pkg.sv
hdl/sketch_pkg.sv
hdl/flow_collector.sv
hdl/flow_hash.sv
hdl/sketch_table.sv
hdl/sketch_axil_read.sv
hdl/flow_sketch_top.sv
verification/flow_sketch_tb.sv

/* Bender.yml */
package:
  name: flow_sketch

sources:
  # packages first, then blocks, then the top level
  - hdl/stream_pkg.sv
  - hdl/sketch_pkg.sv
  - hdl/flow_collector.sv
  - hdl/flow_hash.sv
  - hdl/sketch_table.sv
  - hdl/sketch_axil_read.sv
  - hdl/flow_sketch_top.sv
  - target: test
    files:
      - verification/flow_sketch_tb.sv
